/* Makefile */
# Verilator build and run of the branch pre-decode testbench.

VERILATOR ?= verilator
TOP       ?= predecode_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# The log decides the verdict, so a failing run makes grep return non-zero.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/predecode_checker.sv */
// Bound checker for reset and redirect-bubble behavior of the pre-decode stage.
`timescale 1ns/1ns

module predecode_checker
(
        input  logic    i_clk,
        input  logic    i_reset,
        input  logic    i_clear_from_writeback,
        input  logic    i_data_stall,
        input  logic    i_clear_from_alu,
        input  logic    i_stall_from_shifter,
        input  logic    i_stall_from_issue,
        input  logic    i_instruction_valid,
        input  logic    i_clear_from_decode
);

logic   outer_request;

// Any clear or stall that outranks the stage's own redirect.
assign outer_request = i_clear_from_writeback || i_data_stall || i_clear_from_alu ||
                       i_stall_from_shifter || i_stall_from_issue;

// Reset leaves no valid instruction and no redirect.
reset_quiet: assert property (@(posedge i_clk)
        i_reset |=> !i_instruction_valid && !i_clear_from_decode)
        else $error("Valid or redirect high after a reset cycle");

// Own redirect is followed by a bubble.
redirect_bubble: assert property (@(posedge i_clk) disable iff (i_reset)
        i_clear_from_decode && !outer_request |=> !i_instruction_valid)
        else $error("No bubble after the stage's own redirect");

// Writeback clear kills the stage.
writeback_kill: assert property (@(posedge i_clk) disable iff (i_reset)
        i_clear_from_writeback |=> !i_instruction_valid && !i_clear_from_decode)
        else $error("Stage still valid after a writeback clear");

endmodule

/* tb/predecode_input.txt */
// ctl nibbles {valid pred_valid thumb taken clr_wb data_stall clr_alu stall_shift stall_issue}
// instr pc pc_plus_8 pred_target exp{valid taken clear clear_btb} exp_pc exp_ppc exp_pc_from_decode
000000000 000000000 00000000 00000000 00000000 0000 00000000 00000000 00000000
100000000 0EB000010 00001000 00001008 00000000 1310 00001000 00001048 00001048
100000000 0E0812003 00001004 0000100C 00000000 0000 00000000 00000000 00000000
100000000 0E12FFF1E 00002000 00002008 00000000 1310 00002000 00001004 00001004
000000000 000000000 00000000 00000000 00000000 0000 00000000 00000000 00000000
110300000 0EB000020 00003000 00003008 00003088 1300 00003000 00003088 00003088
111200000 0E0812003 00004000 00004008 00005000 1011 00004000 00004002 00004002
000000000 000000000 00000000 00000000 00000000 0000 00000000 00000000 00000000
110200000 0E591F004 00006000 00006008 00006100 1200 00006000 00000000 00000000
100100000 0E1A0F002 00006004 0000600C 00000000 1100 00006004 00000000 00000000
100000010 0EB000004 00007000 00007008 00000000 1100 00006004 00000000 00000000
100001100 0EB000004 00007000 00007008 00000000 1100 00006004 00000000 00000000
100000100 0EB000004 00007000 00007008 00000000 0000 00006004 00000000 00000000
100010001 0EB000004 00007000 00007008 00000000 0000 00006004 00000000 00000000
110300000 0E12FFF1E 00008000 00008008 00003004 1300 00008000 00003004 00003004
100100000 01B000008 00009000 00009008 00000000 1100 00009000 00009004 00000000
111200000 40A000002 0000A000 0000A004 0000A100 1210 0000A000 0000A008 0000A008
101000000 0E0812003 0000A002 0000A006 00000000 0000 00000000 00000000 00000000
110300000 0CBFFFFFC 0000C000 0000C008 0000BFF8 1300 0000C000 0000BFF8 0000BFF8
100000000 0E8BD8010 0000D000 0000D008 00000000 1310 0000D000 0000C004 0000C004
000000010 000000000 00000000 00000000 00000000 1310 0000D000 0000C004 0000C004
000000000 000000000 00000000 00000000 00000000 0000 00000000 00000000 00000000

/* tb/predecode_tb.sv */
// Testbench for the branch pre-decode stage, driven and checked from a vector file.
`timescale 1ns/1ns
`include "predecode_params.svh"

module predecode_tb;

import predecode_pkg::*;

localparam int CLK_PERIOD     = 8;
localparam int RESET_CYCLES   = 16;
localparam int NUM_VEC        = 22;
localparam int VEC_WORDS      = 9;
localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * NUM_VEC + 20;

logic                           i_clk;
logic                           i_reset;
logic [`PD_INSTR_W-1:0]         i_instruction;
logic                           i_instruction_valid;
logic [`PD_ADDR_W-1:0]          i_pc;
logic [`PD_ADDR_W-1:0]          i_pc_plus_8;
logic                           i_pred_valid;
logic [`PD_ADDR_W-1:0]          i_pred_target;
branch_state_t                  i_taken;
logic                           i_thumb;
logic                           i_clear_from_writeback;
logic                           i_data_stall;
logic                           i_clear_from_alu;
logic                           i_stall_from_shifter;
logic                           i_stall_from_issue;

logic [`PD_INSTR_W-1:0]         o_instruction;
logic                           o_instruction_valid;
logic [`PD_ADDR_W-1:0]          o_pc;
logic [`PD_ADDR_W-1:0]          o_pc_plus_8;
logic [`PD_ADDR_W-1:0]          o_ppc;
branch_state_t                  o_taken;
logic                           o_clear_from_decode;
logic [`PD_ADDR_W-1:0]          o_pc_from_decode;
logic                           o_clear_btb;

// Nine words per vector hold ctl, instr, pc, pc+8, pred, expected flags, pc, ppc and redirect pc.
logic [35:0]                    vec_mem [NUM_VEC*VEC_WORDS];
int                             cycle_count = 0;
int                             error_count = 0;

// Expected instruction and pc_plus_8 after the edge that takes the current vector.
logic [`PD_INSTR_W-1:0]         exp_instruction;
logic [`PD_ADDR_W-1:0]          exp_pc_plus_8;

predecode_top u_predecode_top (.*);

bind predecode_top predecode_checker u_predecode_checker
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_shifter   (i_stall_from_shifter),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_instruction_valid    (o_instruction_valid),
        .i_clear_from_decode    (o_clear_from_decode)
);

//////////////////////////////////////////////////////////////
// Clock and run limit.
//////////////////////////////////////////////////////////////

initial
begin
        i_clk = 1'b0;
        forever
                #(CLK_PERIOD / 2) i_clk = ~i_clk;
end

always @ (posedge i_clk)
begin
        cycle_count <= cycle_count + 1;
        if ( cycle_count >= TIMEOUT_CYCLES )
        begin
                $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
                $display("test failed");
                $fatal(1);
        end
end

//////////////////////////////////////////////////////////////
// Helpers.
//////////////////////////////////////////////////////////////

task automatic abort_on_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
endtask

task automatic check_value(input int v, input string name,
                           input logic [35:0] got, input logic [35:0] exp);
        assert ( got === exp )
        else
                abort_on_error($sformatf("ERR %0t ns: vector %0d %s is %h, expected %h",
                                         $time, v, name, got, exp));
endtask

task automatic clear_inputs();
        i_instruction          = '0;
        i_instruction_valid    = 1'b0;
        i_pc                   = '0;
        i_pc_plus_8            = '0;
        i_pred_valid           = 1'b0;
        i_pred_target          = '0;
        i_taken                = SNT;
        i_thumb                = 1'b0;
        i_clear_from_writeback = 1'b0;
        i_data_stall           = 1'b0;
        i_clear_from_alu       = 1'b0;
        i_stall_from_shifter   = 1'b0;
        i_stall_from_issue     = 1'b0;
endtask

// One flag per nibble of the control word.
task automatic apply_vector(input int v);
        logic [35:0] ctl;
        int          base;
        base                   = v * VEC_WORDS;
        ctl                    = vec_mem[base];
        i_instruction_valid    = ctl[32];
        i_pred_valid           = ctl[28];
        i_thumb                = ctl[24];
        i_taken                = branch_state_t'(ctl[21:20]);
        i_clear_from_writeback = ctl[16];
        i_data_stall           = ctl[12];
        i_clear_from_alu       = ctl[8];
        i_stall_from_shifter   = ctl[4];
        i_stall_from_issue     = ctl[0];
        i_instruction          = vec_mem[base + 1][`PD_INSTR_W-1:0];
        i_pc                   = vec_mem[base + 2][`PD_ADDR_W-1:0];
        i_pc_plus_8            = vec_mem[base + 3][`PD_ADDR_W-1:0];
        i_pred_target          = vec_mem[base + 4][`PD_ADDR_W-1:0];
endtask

// A redirect with nothing above it leaves a bubble, clears and stalls keep the old values.
task automatic predict_pass_through(input int v);
        logic [35:0] ctl;
        logic        outer;
        logic        bubble;
        ctl    = vec_mem[v * VEC_WORDS];
        outer  = ctl[16] || ctl[12] || ctl[8] || ctl[4] || ctl[0];
        bubble = 1'b0;
        if ( v > 0 )
                bubble = vec_mem[(v - 1) * VEC_WORDS + 5][4];
        if ( bubble && !outer )
        begin
                exp_instruction = '0;
                exp_pc_plus_8   = '0;
        end
        else if ( !outer )
        begin
                exp_instruction = vec_mem[v * VEC_WORDS + 1][`PD_INSTR_W-1:0];
                exp_pc_plus_8   = vec_mem[v * VEC_WORDS + 3][`PD_ADDR_W-1:0];
        end
endtask

task automatic check_clear_btb(input int v);
        check_value(v, "o_clear_btb", 36'(o_clear_btb), 36'(vec_mem[v * VEC_WORDS + 5][0]));
endtask

task automatic check_outputs(input int v);
        logic [35:0] exp;
        int          base;
        base = v * VEC_WORDS;
        exp  = vec_mem[base + 5];
        check_value(v, "o_instruction_valid", 36'(o_instruction_valid), 36'(exp[12]));
        check_value(v, "o_taken", 36'(o_taken), 36'(exp[9:8]));
        check_value(v, "o_clear_from_decode", 36'(o_clear_from_decode), 36'(exp[4]));
        check_value(v, "o_pc", 36'(o_pc), vec_mem[base + 6]);
        check_value(v, "o_ppc", 36'(o_ppc), vec_mem[base + 7]);
        check_value(v, "o_pc_from_decode", 36'(o_pc_from_decode), vec_mem[base + 8]);
        check_value(v, "o_instruction", 36'(o_instruction), 36'(exp_instruction));
        check_value(v, "o_pc_plus_8", 36'(o_pc_plus_8), 36'(exp_pc_plus_8));
endtask

//////////////////////////////////////////////////////////////
// Stimulus.
//////////////////////////////////////////////////////////////

initial
begin
        i_reset = 1'b1;
        clear_inputs();
        exp_instruction = '0;
        exp_pc_plus_8   = '0;

        // Sentinel in the last word shows whether the whole file was read.
        vec_mem[NUM_VEC*VEC_WORDS-1] = '1;
        $readmemh("tb/predecode_input.txt", vec_mem);
        assert ( vec_mem[NUM_VEC*VEC_WORDS-1] !== '1 )
        else
                abort_on_error("The vector file is missing or holds too few vectors");

        repeat (RESET_CYCLES) @ (negedge i_clk);
        i_reset = 1'b0;

        // Results of a vector are checked on the falling edge that drives the next one.
        for (int v = 0; v < NUM_VEC; v++)
        begin
                @ (negedge i_clk);
                if ( v > 0 )
                        check_outputs(v - 1);
                apply_vector(v);
                predict_pass_through(v);
                #(CLK_PERIOD / 4);
                check_clear_btb(v);
        end

        @ (negedge i_clk);
        check_outputs(NUM_VEC - 1);

        if ( error_count == 0 )
                $display("test passed");
        else
                $display("test failed");
        $finish;
end

endmodule

/* verilog.f */
+incdir+verilog
verilog/predecode_pkg.sv
verilog/branch_classifier.sv
verilog/return_addr_stack.sv
verilog/branch_resolver.sv
verilog/predecode_pipe_reg.sv
verilog/predecode_top.sv
tb/predecode_checker.sv
tb/predecode_tb.sv

/* verilog/branch_classifier.sv */
// Branch classifier that decodes instruction class, link bit, condition and call offset.
`timescale 1ns/1ns
`include "predecode_params.svh"

module branch_classifier
(
        input  logic [`PD_INSTR_W-1:0]          i_instruction,
        input  logic                            i_instruction_valid,

        output predecode_pkg::instr_class_t     o_class,
        output logic                            o_link,
        output predecode_pkg::cond_t            o_cond,
        output logic [`PD_ADDR_W-1:0]           o_offset
);

import predecode_pkg::*;

// Data processing opcodes.
localparam logic [3:0] OP_ADD = 4'b0100;
localparam logic [3:0] OP_MOV = 4'b1101;

logic                   is_call;
logic                   is_bx_lr;
logic                   is_mov_pc_lr;
logic                   is_ldm_pc;
logic                   is_ldr_pc;
logic                   is_dp_pc;
logic [`PD_ADDR_W-1:0]  offset_ext;

//////////////////////////////////////////////////////////////
// Pattern matching.
//////////////////////////////////////////////////////////////

assign is_call      = i_instruction[27:25] == 3'b101;
assign is_bx_lr     = i_instruction[27:4] == 24'h12FFF1 &&
                      i_instruction[3:0] == 4'(`PD_REG_LR);
assign is_mov_pc_lr = i_instruction[34:32] == 3'd0 &&
                      i_instruction[27:16] == 12'b0001_1010_0000 &&
                      i_instruction[15:12] == 4'(`PD_REG_PC) &&
                      i_instruction[11:4] == 8'd0 &&
                      i_instruction[3:0] == 4'(`PD_REG_LR);
assign is_ldm_pc    = i_instruction[27:25] == 3'b100 && i_instruction[20] &&
                      i_instruction[15];

// Immediate form, or register form with an immediate shift.
assign is_ldr_pc    = i_instruction[27:26] == 2'b01 &&
                      (!i_instruction[25] || !i_instruction[4]) &&
                      i_instruction[20] && i_instruction[15:12] == 4'(`PD_REG_PC);

// Register-shifted-register forms are excluded.
assign is_dp_pc     = i_instruction[27:26] == 2'b00 &&
                      i_instruction[15:12] == 4'(`PD_REG_PC) &&
                      (i_instruction[25] || !i_instruction[4] || !i_instruction[7]) &&
                      (i_instruction[24:21] == OP_ADD || i_instruction[24:21] == OP_MOV);

always_comb
begin
        if ( !i_instruction_valid )
                o_class = NONE;
        else if ( is_call )
                o_class = CALL;
        else if ( is_bx_lr || is_mov_pc_lr || is_ldm_pc ||
                  (is_ldr_pc && i_instruction[19:16] == 4'(`PD_REG_SP)) )
                o_class = RETURN;
        else if ( is_ldr_pc || is_dp_pc )
                o_class = JUMP_TABLE;
        else
                o_class = OTHER;
end

//////////////////////////////////////////////////////////////
// Fields.
//////////////////////////////////////////////////////////////

assign o_link     = i_instruction[24];
assign o_cond     = i_instruction[31:28];
assign offset_ext = {{(`PD_ADDR_W-24){i_instruction[23]}}, i_instruction[23:0]};

// Halfword scaling in Thumb, word scaling otherwise.
assign o_offset   = i_instruction[34] ? offset_ext << 1 : offset_ext << 2;

endmodule

/* verilog/branch_resolver.sv */
// Branch resolver that confirms or overrides the fetch prediction and drives the stack.
`timescale 1ns/1ns

module branch_resolver
#(
        parameter int ADDR_W = 32
)
(
        input  predecode_pkg::instr_class_t     i_class,
        input  logic                            i_link,
        input  predecode_pkg::cond_t            i_cond,
        input  logic [ADDR_W-1:0]               i_offset,
        input  logic [ADDR_W-1:0]               i_pc,
        input  logic [ADDR_W-1:0]               i_pc_plus_8,
        input  logic                            i_thumb,
        input  predecode_pkg::branch_state_t    i_taken,
        input  logic                            i_pred_valid,
        input  logic [ADDR_W-1:0]               i_pred_target,
        input  logic [ADDR_W-1:0]               i_top_addr,
        input  logic [ADDR_W-1:0]               i_ppc_prev,

        output predecode_pkg::branch_state_t    o_taken_nxt,
        output logic [ADDR_W-1:0]               o_ppc_nxt,
        output logic                            o_clear_nxt,
        output logic [ADDR_W-1:0]               o_pc_from_decode_nxt,
        output logic                            o_push,
        output logic                            o_pop,
        output logic [ADDR_W-1:0]               o_push_addr,
        output logic                            o_clear_btb
);

import predecode_pkg::*;

logic [ADDR_W-1:0]      seq_pc;
logic [ADDR_W-1:0]      target;
logic                   take;
logic                   mispredict;

assign seq_pc      = i_pc + (i_thumb ? ADDR_W'(2) : ADDR_W'(4));
assign o_push_addr = seq_pc;

// Taken if the predictor leans taken or the branch cannot fail.
assign take       = i_taken == WT || i_taken == ST || i_cond == COND_AL;
assign target     = (i_class == CALL) ? i_pc_plus_8 + i_offset : i_top_addr;
assign mispredict = !i_pred_valid || i_pred_target != target;

always_comb
begin
        o_taken_nxt          = i_taken;
        o_ppc_nxt            = i_ppc_prev;
        o_clear_nxt          = 1'b0;
        o_pc_from_decode_nxt = '0;
        o_push               = 1'b0;
        o_pop                = 1'b0;
        o_clear_btb          = 1'b0;

        case ( i_class )
        CALL, RETURN:
        begin
                if ( take )
                begin
                        o_pc_from_decode_nxt = target;
                        o_ppc_nxt            = target;
                        o_clear_nxt          = mispredict;
                        o_push               = i_class == CALL && i_link;
                        o_pop                = i_class == RETURN;

                        if ( i_cond == COND_AL )
                                o_taken_nxt = ST;
                end
                else
                begin
                        o_ppc_nxt = seq_pc;
                end
        end

        JUMP_TABLE:
        begin
                // Trust the BTB.
        end

        OTHER:
        begin
                o_taken_nxt = SNT;

                // A non-branch cannot have a target, so the BTB entry is stale.
                if ( i_pred_valid )
                begin
                        o_clear_nxt          = 1'b1;
                        o_pc_from_decode_nxt = seq_pc;
                        o_ppc_nxt            = seq_pc;
                        o_clear_btb          = 1'b1;
                end
        end

        default:
        begin
                o_taken_nxt = SNT;
        end
        endcase
end

endmodule

/* verilog/predecode_params.svh */
// Width, stack depth and architectural register macros for the branch pre-decode stage.
`ifndef PREDECODE_PARAMS_SVH
`define PREDECODE_PARAMS_SVH

// Width of program counters and branch targets.
`define PD_ADDR_W       32

// Instruction word plus decoder side bits.
// Bit 34 selects halfword scaling of the branch offset.
`define PD_INSTR_W      35

// Number of return-address stack entries.
`define PD_RAS_DEPTH    8

// Architectural register numbers.
`define PD_REG_PC       15
`define PD_REG_LR       14
`define PD_REG_SP       13

`endif

/* verilog/predecode_pipe_reg.sv */
// Output register of the pre-decode stage with clear/stall priority and redirect bubble.
`timescale 1ns/1ns

module predecode_pipe_reg
#(
        parameter int ADDR_W  = 32,
        parameter int INSTR_W = 35
)
(
        input  logic                            i_clk,
        input  logic                            i_reset,

        // From high to low priority.
        input  logic                            i_clear_from_writeback,
        input  logic                            i_data_stall,
        input  logic                            i_clear_from_alu,
        input  logic                            i_stall_from_shifter,
        input  logic                            i_stall_from_issue,

        input  logic [INSTR_W-1:0]              i_instruction_nxt,
        input  logic                            i_instruction_valid_nxt,
        input  logic [ADDR_W-1:0]               i_pc_nxt,
        input  logic [ADDR_W-1:0]               i_pc_plus_8_nxt,
        input  predecode_pkg::branch_state_t    i_taken_nxt,
        input  logic [ADDR_W-1:0]               i_ppc_nxt,
        input  logic                            i_clear_nxt,
        input  logic [ADDR_W-1:0]               i_pc_from_decode_nxt,

        output logic [INSTR_W-1:0]              o_instruction,
        output logic                            o_instruction_valid,
        output logic [ADDR_W-1:0]               o_pc,
        output logic [ADDR_W-1:0]               o_pc_plus_8,
        output predecode_pkg::branch_state_t    o_taken,
        output logic [ADDR_W-1:0]               o_ppc,
        output logic                            o_clear_from_decode,
        output logic [ADDR_W-1:0]               o_pc_from_decode,
        output logic                            o_advance
);

import predecode_pkg::*;

// New values load only when nothing clears, stalls or bubbles the stage.
assign o_advance = !(i_clear_from_writeback || i_data_stall || i_clear_from_alu ||
                     i_stall_from_shifter || i_stall_from_issue || o_clear_from_decode);

always_ff @ (posedge i_clk)
begin
        if ( i_reset || (o_clear_from_decode && !i_clear_from_writeback &&
                         !i_data_stall && !i_clear_from_alu &&
                         !i_stall_from_shifter && !i_stall_from_issue) )
        begin
                // Reset, or the bubble behind our own redirect.
                o_instruction       <= '0;
                o_instruction_valid <= 1'b0;
                o_pc                <= '0;
                o_pc_plus_8         <= '0;
                o_taken             <= SNT;
                o_ppc               <= '0;
                o_clear_from_decode <= 1'b0;
                o_pc_from_decode    <= '0;
        end
        else if ( i_clear_from_writeback || (!i_data_stall && i_clear_from_alu) )
        begin
                // PCs are left alone.
                o_instruction_valid <= 1'b0;
                o_taken             <= SNT;
                o_clear_from_decode <= 1'b0;
        end
        else if ( o_advance )
        begin
                o_instruction       <= i_instruction_nxt;
                o_instruction_valid <= i_instruction_valid_nxt;
                o_pc                <= i_pc_nxt;
                o_pc_plus_8         <= i_pc_plus_8_nxt;
                o_taken             <= i_taken_nxt;
                o_ppc               <= i_ppc_nxt;
                o_clear_from_decode <= i_clear_nxt;
                o_pc_from_decode    <= i_pc_from_decode_nxt;
        end
        // Otherwise a stall holds every output.
end

endmodule

/* verilog/predecode_pkg.sv */
// Shared branch-state, instruction-class and condition types for the pre-decode stage.
package predecode_pkg;

        //////////////////////////////////////////////////////////////
        // Two-bit branch predictor state.
        //////////////////////////////////////////////////////////////

        typedef enum logic [1:0]
        {
                SNT = 2'd0,     // Strongly not taken.
                WNT = 2'd1,     // Weakly not taken.
                WT  = 2'd2,     // Weakly taken.
                ST  = 2'd3      // Strongly taken.
        } branch_state_t;

        //////////////////////////////////////////////////////////////
        // Instruction classes seen by the branch predictor.
        //////////////////////////////////////////////////////////////

        typedef enum logic [2:0]
        {
                CALL       = 3'd0,
                RETURN     = 3'd1,
                JUMP_TABLE = 3'd2,
                OTHER      = 3'd3,
                NONE       = 3'd4
        } instr_class_t;

        //////////////////////////////////////////////////////////////
        // Condition field.
        //////////////////////////////////////////////////////////////

        typedef logic [3:0] cond_t;

        // Unconditional execution.
        localparam cond_t COND_AL = 4'b1110;

endpackage

/* verilog/predecode_top.sv */
// Branch pre-decode stage top level joining classifier, resolver, stack and output register.
`timescale 1ns/1ns
`include "predecode_params.svh"

module predecode_top
(
        input  logic                            i_clk,
        input  logic                            i_reset,

        input  logic [`PD_INSTR_W-1:0]          i_instruction,
        input  logic                            i_instruction_valid,
        input  logic [`PD_ADDR_W-1:0]           i_pc,
        input  logic [`PD_ADDR_W-1:0]           i_pc_plus_8,

        // BTB guess from fetch.
        input  logic                            i_pred_valid,
        input  logic [`PD_ADDR_W-1:0]           i_pred_target,
        input  predecode_pkg::branch_state_t    i_taken,
        input  logic                            i_thumb,

        // From high to low priority.
        input  logic                            i_clear_from_writeback,
        input  logic                            i_data_stall,
        input  logic                            i_clear_from_alu,
        input  logic                            i_stall_from_shifter,
        input  logic                            i_stall_from_issue,

        output logic [`PD_INSTR_W-1:0]          o_instruction,
        output logic                            o_instruction_valid,
        output logic [`PD_ADDR_W-1:0]           o_pc,
        output logic [`PD_ADDR_W-1:0]           o_pc_plus_8,
        output logic [`PD_ADDR_W-1:0]           o_ppc,
        output predecode_pkg::branch_state_t    o_taken,
        output logic                            o_clear_from_decode,
        output logic [`PD_ADDR_W-1:0]           o_pc_from_decode,
        output logic                            o_clear_btb
);

import predecode_pkg::*;

instr_class_t           cls;
cond_t                  cond;
logic                   link;
logic [`PD_ADDR_W-1:0]  offset;
branch_state_t          taken_nxt;
logic [`PD_ADDR_W-1:0]  ppc_nxt;
logic                   clear_nxt;
logic [`PD_ADDR_W-1:0]  pc_from_decode_nxt;
logic                   ras_push;
logic                   ras_pop;
logic [`PD_ADDR_W-1:0]  ras_push_addr;
logic [`PD_ADDR_W-1:0]  ras_top_addr;
logic                   advance;

//////////////////////////////////////////////////////////////
// Decode and prediction.
//////////////////////////////////////////////////////////////

branch_classifier u_branch_classifier
(
        .i_instruction          (i_instruction),
        .i_instruction_valid    (i_instruction_valid),
        .o_class                (cls),
        .o_link                 (link),
        .o_cond                 (cond),
        .o_offset               (offset)
);

branch_resolver #(.ADDR_W(`PD_ADDR_W)) u_branch_resolver
(
        .i_class                (cls),
        .i_link                 (link),
        .i_cond                 (cond),
        .i_offset               (offset),
        .i_pc                   (i_pc),
        .i_pc_plus_8            (i_pc_plus_8),
        .i_thumb                (i_thumb),
        .i_taken                (i_taken),
        .i_pred_valid           (i_pred_valid),
        .i_pred_target          (i_pred_target),
        .i_top_addr             (ras_top_addr),
        .i_ppc_prev             (o_ppc),
        .o_taken_nxt            (taken_nxt),
        .o_ppc_nxt              (ppc_nxt),
        .o_clear_nxt            (clear_nxt),
        .o_pc_from_decode_nxt   (pc_from_decode_nxt),
        .o_push                 (ras_push),
        .o_pop                  (ras_pop),
        .o_push_addr            (ras_push_addr),
        .o_clear_btb            (o_clear_btb)
);

//////////////////////////////////////////////////////////////
// State.
//////////////////////////////////////////////////////////////

// Stack moves on the same edge as the outputs.
return_addr_stack u_return_addr_stack
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_advance              (advance),
        .i_push                 (ras_push),
        .i_pop                  (ras_pop),
        .i_push_addr            (ras_push_addr),
        .o_top_addr             (ras_top_addr)
);

predecode_pipe_reg #(.ADDR_W(`PD_ADDR_W), .INSTR_W(`PD_INSTR_W)) u_predecode_pipe_reg
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_shifter   (i_stall_from_shifter),
        .i_stall_from_issue     (i_stall_from_issue),
        .i_instruction_nxt      (i_instruction),
        .i_instruction_valid_nxt(i_instruction_valid),
        .i_pc_nxt               (i_pc),
        .i_pc_plus_8_nxt        (i_pc_plus_8),
        .i_taken_nxt            (taken_nxt),
        .i_ppc_nxt              (ppc_nxt),
        .i_clear_nxt            (clear_nxt),
        .i_pc_from_decode_nxt   (pc_from_decode_nxt),
        .o_instruction          (o_instruction),
        .o_instruction_valid    (o_instruction_valid),
        .o_pc                   (o_pc),
        .o_pc_plus_8            (o_pc_plus_8),
        .o_taken                (o_taken),
        .o_ppc                  (o_ppc),
        .o_clear_from_decode    (o_clear_from_decode),
        .o_pc_from_decode       (o_pc_from_decode),
        .o_advance              (advance)
);

endmodule

/* verilog/return_addr_stack.sv */
// Circular return-address stack with push, pop and a registered pointer.
`timescale 1ns/1ns
`include "predecode_params.svh"

module return_addr_stack
(
        input  logic                            i_clk,
        input  logic                            i_reset,

        // Push and pop commit only when the stage advances.
        input  logic                            i_advance,
        input  logic                            i_push,
        input  logic                            i_pop,
        input  logic [`PD_ADDR_W-1:0]           i_push_addr,

        output logic [`PD_ADDR_W-1:0]           o_top_addr
);

localparam int PTR_W = $clog2(`PD_RAS_DEPTH);

logic [`PD_ADDR_W-1:0]  ras_mem [`PD_RAS_DEPTH];
logic [PTR_W-1:0]       ras_ptr;
logic [PTR_W-1:0]       top_idx;

// Most recent entry sits just below the pointer.
assign top_idx    = ras_ptr - 1'b1;
assign o_top_addr = ras_mem[top_idx];

//////////////////////////////////////////////////////////////
// Pointer.
//////////////////////////////////////////////////////////////

always_ff @ (posedge i_clk)
begin
        if ( i_reset )
                ras_ptr <= '0;
        else if ( i_advance && i_push )
                ras_ptr <= ras_ptr + 1'b1;      // Wraps, oldest entry is overwritten.
        else if ( i_advance && i_pop )
                ras_ptr <= top_idx;
end

//////////////////////////////////////////////////////////////
// Entries.
//////////////////////////////////////////////////////////////

always_ff @ (posedge i_clk)
begin
        if ( i_advance && i_push )
                ras_mem[ras_ptr] <= i_push_addr;
end

endmodule
